//--- logic/apb_ss_pkg.sv
// APB subsystem shared definitions
package apb_ss_pkg;

  // ========================================================================
  // Sizes
  // ========================================================================
  localparam int NUM_BANKS  = 4;   // GPIO banks behind the bridge
  localparam int BANK_WIDTH = 8;   // Pins per bank
  localparam int AHB_DW     = 32;
  localparam int AHB_AW     = 32;

  // ========================================================================
  // Address map
  // ========================================================================
  localparam int BANK_MSB = 11;    // Bank number field of haddr
  localparam int BANK_LSB = 8;
  localparam int REG_MSB  = 4;     // Word offset inside a bank
  localparam int REG_LSB  = 2;

  // AHB transfer and response codes
  localparam logic [1:0] HTRANS_NONSEQ = 2'b10;
  localparam logic [1:0] HTRANS_SEQ    = 2'b11;
  localparam logic [1:0] HRESP_OKAY    = 2'b00;
  localparam logic [1:0] HRESP_ERROR   = 2'b01;

  // Register offsets, 5 to 7 undefined
  typedef enum logic [2:0] {
    REG_DOUT     = 3'd0,           // Output data
    REG_DIR      = 3'd1,           // 1 = output
    REG_DIN      = 3'd2,           // Synchronized pins, read only
    REG_IRQ_STAT = 3'd3,           // Rising-edge status, write 1 to clear
    REG_IRQ_MASK = 3'd4            // 1 = interrupt enabled
  } reg_offset_e;

  // Bridge FSM
  typedef enum logic [2:0] {
    ST_IDLE,
    ST_SETUP,                      // APB setup phase
    ST_ACCESS,                     // APB access phase
    ST_DONE,                       // AHB data phase ends OKAY
    ST_ERR1,                       // First ERROR cycle, hready low
    ST_ERR2                        // Second ERROR cycle, hready high
  } bridge_state_e;

endpackage

//--- logic/ahb_apb_bridge.sv
// AHB-lite to APB bridge
`timescale 1ns/1ps

module ahb_apb_bridge (
  input  logic                              tb_hclk19,
  input  logic                              hresetn19,
  // AHB-lite slave side
  input  logic                              i_hsel,
  input  logic [apb_ss_pkg::AHB_AW-1:0]     i_haddr,
  input  logic [1:0]                        i_htrans,
  input  logic                              i_hwrite,
  input  logic [apb_ss_pkg::AHB_DW-1:0]     i_hwdata,
  input  logic                              i_hready_in,
  output logic [apb_ss_pkg::AHB_DW-1:0]     o_hrdata,
  output logic                              o_hready,
  output logic [1:0]                        o_hresp,
  // APB master side
  input  logic [apb_ss_pkg::BANK_WIDTH-1:0] i_prdata,
  output logic [apb_ss_pkg::NUM_BANKS-1:0]  o_psel,
  output logic                              o_penable,
  output logic                              o_pwrite,
  output apb_ss_pkg::reg_offset_e           o_paddr,
  output logic [apb_ss_pkg::BANK_WIDTH-1:0] o_pwdata
);
  import apb_ss_pkg::*;

  bridge_state_e               state_q;
  bridge_state_e               state_d;
  logic                        accept;        // Address phase taken this cycle
  logic                        addr_ok;       // Bank and offset both defined
  logic [BANK_MSB-BANK_LSB:0]  bank_field;
  logic [REG_MSB-REG_LSB:0]    reg_field;
  logic [BANK_MSB-BANK_LSB:0]  bank_q;
  reg_offset_e                 paddr_q;
  logic                        write_q;
  logic [BANK_WIDTH-1:0]       pwdata_q;
  logic [AHB_DW-1:0]           hrdata_q;
  logic [NUM_BANKS-1:0]        psel_dec;

  // ========================================================================
  // Address phase decode
  // ========================================================================
  assign bank_field = i_haddr[BANK_MSB:BANK_LSB];
  assign reg_field  = i_haddr[REG_MSB:REG_LSB];
  assign addr_ok    = (bank_field < NUM_BANKS) && (reg_field <= REG_IRQ_MASK);

  // hready high only in IDLE, DONE and ERR2
  assign o_hready = (state_q == ST_IDLE) || (state_q == ST_DONE) || (state_q == ST_ERR2);
  assign accept   = i_hsel && i_hready_in && o_hready &&
                    ((i_htrans == HTRANS_NONSEQ) || (i_htrans == HTRANS_SEQ));

  // ========================================================================
  // FSM
  // ========================================================================
  always_comb begin
    state_d = state_q;
    case (state_q)
      ST_IDLE, ST_DONE, ST_ERR2: begin
        if (accept) begin
          state_d = addr_ok ? ST_SETUP : ST_ERR1;  // Bad address never reaches APB
        end else begin
          state_d = ST_IDLE;
        end
      end
      ST_SETUP:  state_d = ST_ACCESS;
      ST_ACCESS: state_d = ST_DONE;                // Banks have no wait states
      ST_ERR1:   state_d = ST_ERR2;
      default:   state_d = ST_IDLE;
    endcase
  end

  always_ff @(posedge tb_hclk19) begin
    if (!hresetn19) begin
      state_q <= ST_IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  // Address, direction and bank held for the whole data phase
  always_ff @(posedge tb_hclk19) begin
    if (accept) begin
      bank_q  <= bank_field;
      paddr_q <= reg_offset_e'(reg_field);
      write_q <= i_hwrite;
    end
    // Write data arrives one cycle after the address
    if (state_q == ST_SETUP) begin
      pwdata_q <= i_hwdata[BANK_WIDTH-1:0];
    end
    if ((state_q == ST_ACCESS) && !write_q) begin
      hrdata_q <= AHB_DW'(i_prdata);             // Zero-extended byte
    end
  end

  // ========================================================================
  // APB outputs
  // ========================================================================
  assign psel_dec  = {{(NUM_BANKS-1){1'b0}}, 1'b1} << bank_q;
  assign o_psel    = ((state_q == ST_SETUP) || (state_q == ST_ACCESS)) ? psel_dec : '0;
  assign o_penable = (state_q == ST_ACCESS);
  assign o_pwrite  = write_q;
  assign o_paddr   = paddr_q;
  assign o_pwdata  = pwdata_q;                   // Sampled by banks only in ACCESS

  assign o_hrdata = hrdata_q;
  assign o_hresp  = ((state_q == ST_ERR1) || (state_q == ST_ERR2)) ? HRESP_ERROR
                                                                    : HRESP_OKAY;

  // Exactly one bank selected while an APB access runs
  a_psel_onehot : assert property (
    @(posedge tb_hclk19) disable iff (!hresetn19)
    ((state_q == ST_SETUP) || (state_q == ST_ACCESS)) |-> $onehot(o_psel)
  ) else $error("bridge: psel is not one-hot during an APB access");

  // Access phase always preceded by a setup phase
  a_penable_after_setup : assert property (
    @(posedge tb_hclk19) disable iff (!hresetn19)
    o_penable |-> $past((|o_psel) && !o_penable)
  ) else $error("bridge: penable without a setup cycle");

endmodule

//--- logic/gpio_bank.sv
// GPIO bank with edge interrupts
`timescale 1ns/1ps

module gpio_bank (
  input  logic                              tb_hclk19,
  input  logic                              hresetn19,
  input  logic                              i_psel,
  input  logic                              i_penable,
  input  logic                              i_pwrite,
  input  apb_ss_pkg::reg_offset_e           i_paddr,
  input  logic [apb_ss_pkg::BANK_WIDTH-1:0] i_pwdata,
  input  logic [apb_ss_pkg::BANK_WIDTH-1:0] i_gpio_in,
  output logic [apb_ss_pkg::BANK_WIDTH-1:0] o_prdata,
  output logic [apb_ss_pkg::BANK_WIDTH-1:0] o_gpio_out,
  output logic [apb_ss_pkg::BANK_WIDTH-1:0] o_gpio_n_oe,
  output logic                              o_irq
);
  import apb_ss_pkg::*;

  logic [BANK_WIDTH-1:0] dout_q;
  logic [BANK_WIDTH-1:0] dir_q;
  logic [BANK_WIDTH-1:0] mask_q;
  logic [BANK_WIDTH-1:0] stat_q;
  logic [BANK_WIDTH-1:0] sync1_q;   // First synchronizer flop
  logic [BANK_WIDTH-1:0] sync2_q;   // Stable pin level, read as DIN
  logic [BANK_WIDTH-1:0] sync3_q;   // Previous level for edge detect
  logic [BANK_WIDTH-1:0] rise;
  logic [BANK_WIDTH-1:0] clr;
  logic                  wr_en;

  assign wr_en = i_psel && i_penable && i_pwrite;  // APB write in ACCESS

  // ========================================================================
  // Control registers
  // ========================================================================
  always_ff @(posedge tb_hclk19) begin
    if (!hresetn19) begin
      dout_q <= '0;
      dir_q  <= '0;                                // All pins inputs
      mask_q <= '0;
    end else if (wr_en) begin
      case (i_paddr)
        REG_DOUT:     dout_q <= i_pwdata;
        REG_DIR:      dir_q  <= i_pwdata;
        REG_IRQ_MASK: mask_q <= i_pwdata;
        default: ;                                 // DIN read only, STAT below
      endcase
    end
  end

  // Input synchronizer and edge detect
  always_ff @(posedge tb_hclk19) begin
    if (!hresetn19) begin
      sync1_q <= '0;
      sync2_q <= '0;
      sync3_q <= '0;
    end else begin
      sync1_q <= i_gpio_in;
      sync2_q <= sync1_q;
      sync3_q <= sync2_q;
    end
  end

  assign rise = sync2_q & ~sync3_q;
  assign clr  = (wr_en && (i_paddr == REG_IRQ_STAT)) ? i_pwdata : '0;

  // Set has priority over write-one-to-clear
  always_ff @(posedge tb_hclk19) begin
    if (!hresetn19) begin
      stat_q <= '0;
    end else begin
      stat_q <= (stat_q & ~clr) | rise;
    end
  end

  // ========================================================================
  // Read mux and pin outputs
  // ========================================================================
  always_comb begin
    case (i_paddr)
      REG_DOUT:     o_prdata = dout_q;
      REG_DIR:      o_prdata = dir_q;
      REG_DIN:      o_prdata = sync2_q;
      REG_IRQ_STAT: o_prdata = stat_q;
      REG_IRQ_MASK: o_prdata = mask_q;
      default:      o_prdata = '0;
    endcase
  end

  assign o_gpio_out  = dout_q;
  assign o_gpio_n_oe = ~dir_q;                     // Active-low enable
  assign o_irq       = |(stat_q & mask_q);

  // Access strobe on this bank only after its own setup cycle
  a_access_after_setup : assert property (
    @(posedge tb_hclk19) disable iff (!hresetn19)
    (i_psel && i_penable) |-> $past(i_psel && !i_penable)
  ) else $error("gpio_bank: access strobe without setup");

endmodule

//--- logic/apb_read_return.sv
// APB read data and interrupt return
`timescale 1ns/1ps

module apb_read_return (
  input  logic [apb_ss_pkg::NUM_BANKS-1:0]                        i_psel,
  input  logic [apb_ss_pkg::NUM_BANKS*apb_ss_pkg::BANK_WIDTH-1:0] i_prdata_all,
  input  logic [apb_ss_pkg::NUM_BANKS-1:0]                        i_irq_all,
  output logic [apb_ss_pkg::BANK_WIDTH-1:0]                       o_prdata,
  output logic [apb_ss_pkg::NUM_BANKS-1:0]                        o_irq
);
  import apb_ss_pkg::*;

  logic [BANK_WIDTH-1:0] rd_mux;

  // ========================================================================
  // AND-OR read mux
  // ========================================================================
  always_comb begin
    rd_mux = '0;                                   // Zero when nothing selected
    for (int b = 0; b < NUM_BANKS; b++) begin
      rd_mux = rd_mux | (i_prdata_all[b*BANK_WIDTH +: BANK_WIDTH] & {BANK_WIDTH{i_psel[b]}});
    end
    // The OR merge relies on the bridge selecting one bank at most
    a_psel_onehot : assert ($onehot0(i_psel))
      else $error("read_return: more than one bank selected");
  end

  assign o_prdata = rd_mux;

  // One line per bank, not collapsed, so software sees the source bank
  assign o_irq = i_irq_all;

endmodule

//--- logic/apb_ss_top.sv
// APB GPIO subsystem top
`timescale 1ns/1ps

module apb_ss_top (
  input  logic                                                    tb_hclk19,
  input  logic                                                    hresetn19,
  // AHB-lite slave port
  input  logic                                                    i_hsel,
  input  logic [apb_ss_pkg::AHB_AW-1:0]                           i_haddr,
  input  logic [1:0]                                              i_htrans,
  input  logic                                                    i_hwrite,
  input  logic [apb_ss_pkg::AHB_DW-1:0]                           i_hwdata,
  input  logic                                                    i_hready_in,
  output logic [apb_ss_pkg::AHB_DW-1:0]                           o_hrdata,
  output logic                                                    o_hready,
  output logic [1:0]                                              o_hresp,
  // GPIO pins, bank b at [b*BANK_WIDTH +: BANK_WIDTH]
  input  logic [apb_ss_pkg::NUM_BANKS*apb_ss_pkg::BANK_WIDTH-1:0] i_gpio_in,
  output logic [apb_ss_pkg::NUM_BANKS*apb_ss_pkg::BANK_WIDTH-1:0] o_gpio_out,
  output logic [apb_ss_pkg::NUM_BANKS*apb_ss_pkg::BANK_WIDTH-1:0] o_gpio_n_oe,
  output logic [apb_ss_pkg::NUM_BANKS-1:0]                        o_irq
);
  import apb_ss_pkg::*;

  // APB bus, shared except psel
  logic [NUM_BANKS-1:0]            psel;
  logic                            penable;
  logic                            pwrite;
  reg_offset_e                     paddr;
  logic [BANK_WIDTH-1:0]           pwdata;
  logic [BANK_WIDTH-1:0]           prdata;
  logic [NUM_BANKS*BANK_WIDTH-1:0] prdata_all;   // Flat, one slice per bank
  logic [NUM_BANKS-1:0]            irq_all;

  ahb_apb_bridge ahb_apb_bridge_i (
    .tb_hclk19   (tb_hclk19),
    .hresetn19   (hresetn19),
    .i_hsel      (i_hsel),
    .i_haddr     (i_haddr),
    .i_htrans    (i_htrans),
    .i_hwrite    (i_hwrite),
    .i_hwdata    (i_hwdata),
    .i_hready_in (i_hready_in),
    .o_hrdata    (o_hrdata),
    .o_hready    (o_hready),
    .o_hresp     (o_hresp),
    .i_prdata    (prdata),
    .o_psel      (psel),
    .o_penable   (penable),
    .o_pwrite    (pwrite),
    .o_paddr     (paddr),
    .o_pwdata    (pwdata)
  );

  // ========================================================================
  // GPIO banks
  // ========================================================================
  for (genvar g = 0; g < NUM_BANKS; g++) begin : g_bank
    gpio_bank gpio_bank_i (
      .tb_hclk19   (tb_hclk19),
      .hresetn19   (hresetn19),
      .i_psel      (psel[g]),
      .i_penable   (penable),
      .i_pwrite    (pwrite),
      .i_paddr     (paddr),
      .i_pwdata    (pwdata),
      .i_gpio_in   (i_gpio_in[g*BANK_WIDTH +: BANK_WIDTH]),
      .o_prdata    (prdata_all[g*BANK_WIDTH +: BANK_WIDTH]),
      .o_gpio_out  (o_gpio_out[g*BANK_WIDTH +: BANK_WIDTH]),
      .o_gpio_n_oe (o_gpio_n_oe[g*BANK_WIDTH +: BANK_WIDTH]),
      .o_irq       (irq_all[g])
    );
  end

  apb_read_return apb_read_return_i (
    .i_psel       (psel),
    .i_prdata_all (prdata_all),
    .i_irq_all    (irq_all),
    .o_prdata     (prdata),
    .o_irq        (o_irq)
  );

endmodule

//--- verif/apb_ss_tb.sv
// GPIO subsystem testbench
`timescale 1ns/1ps

module apb_ss_tb;
  import apb_ss_pkg::*;

  localparam int HREADY_TIMEOUT = 20;    // Cycles allowed for one data phase
  localparam int IRQ_TIMEOUT    = 10;
  localparam int PIN_SETTLE     = 6;     // Sync, status and irq path

  logic                            tb_hclk19;
  logic                            hresetn19;
  logic                            i_hsel;
  logic [AHB_AW-1:0]               i_haddr;
  logic [1:0]                      i_htrans;
  logic                            i_hwrite;
  logic [AHB_DW-1:0]               i_hwdata;
  logic                            i_hready_in;
  logic [AHB_DW-1:0]               o_hrdata;
  logic                            o_hready;
  logic [1:0]                      o_hresp;
  logic [NUM_BANKS*BANK_WIDTH-1:0] i_gpio_in;
  logic [NUM_BANKS*BANK_WIDTH-1:0] o_gpio_out;
  logic [NUM_BANKS*BANK_WIDTH-1:0] o_gpio_n_oe;
  logic [NUM_BANKS-1:0]            o_irq;

  logic [NUM_BANKS*BANK_WIDTH-1:0] exp_out;  // Expected DOUT of all banks
  logic [NUM_BANKS*BANK_WIDTH-1:0] exp_dir;  // Expected DIR of all banks
  logic [31:0]                     seed;
  logic [31:0]                     addr;
  logic [31:0]                     f_addr;
  logic [31:0]                     f_data;
  logic [31:0]                     f_exp;
  logic [7:0]                      op;
  string                           line;
  int                              fd;
  int                              lineno;
  int                              errors;
  int                              err_mark;
  int                              tests;
  int                              passed;

  apb_ss_top apb_ss_top_i (.*);

  always #4 tb_hclk19 = ~tb_hclk19;      // 8 ns period

  // ==========================================================================
  // Helpers
  // ==========================================================================
  function automatic logic [31:0] lcg_next(input logic [31:0] s);
    return s * 32'd1103515245 + 32'd12345;
  endfunction

  task automatic compare_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
    if (expected !== actual) begin
      $display("mismatch %s: expected %h, actual %h", name, expected, actual);
      errors++;
    end
  endtask

  // One AHB transfer, returns in the last data phase cycle
  task automatic ahb_xfer(input logic wr, input logic [31:0] a, input logic [31:0] wdata,
                          output logic [31:0] rdata, output logic [1:0] resp,
                          output int low);
    int n;
    i_hsel   = 1'b1;
    i_haddr  = a;
    i_htrans = HTRANS_NONSEQ;
    i_hwrite = wr;
    @(posedge tb_hclk19);
    #1;
    i_hsel   = 1'b0;                     // Address phase over
    i_htrans = 2'b00;
    i_hwdata = wdata;                    // Data phase
    low = 0;
    n   = 0;
    while (!o_hready && (n < HREADY_TIMEOUT)) begin
      low++;
      n++;
      @(posedge tb_hclk19);
      #1;
    end
    if (!o_hready) begin
      $display("timeout: o_hready stayed low during the transfer to address %h", a);
      errors++;
    end
    rdata = o_hrdata;
    resp  = o_hresp;
  endtask

  task automatic ahb_write(input logic [31:0] a, input logic [31:0] data);
    logic [31:0] rdata;
    logic [1:0]  resp;
    int          low;
    int          bank;
    bank = a[BANK_MSB:BANK_LSB];
    ahb_xfer(1'b1, a, data, rdata, resp, low);
    compare_value("o_hresp", HRESP_OKAY, resp);
    compare_value("hready_low_cycles", 2, low);  // SETUP and ACCESS
    if (a[REG_MSB:REG_LSB] == REG_DOUT) exp_out[bank*BANK_WIDTH +: BANK_WIDTH] = data[7:0];
    if (a[REG_MSB:REG_LSB] == REG_DIR) exp_dir[bank*BANK_WIDTH +: BANK_WIDTH] = data[7:0];
    compare_value("o_gpio_out", exp_out, o_gpio_out);
    compare_value("o_gpio_n_oe", ~exp_dir, o_gpio_n_oe);  // Other banks untouched
  endtask

  task automatic ahb_read(input logic [31:0] a, input logic [31:0] expected);
    logic [31:0] rdata;
    logic [1:0]  resp;
    int          low;
    ahb_xfer(1'b0, a, 32'h0, rdata, resp, low);
    compare_value("o_hresp", HRESP_OKAY, resp);
    compare_value("hready_low_cycles", 2, low);
    compare_value("o_hrdata", expected, rdata);
  endtask

  // Bad address, two ERROR cycles and no APB access
  task automatic ahb_error(input logic [31:0] a, input logic [31:0] data);
    logic [31:0] rdata;
    logic [1:0]  resp;
    int          low;
    ahb_xfer(1'b1, a, data, rdata, resp, low);
    compare_value("o_hresp", HRESP_ERROR, resp);
    compare_value("hready_low_cycles", 1, low);
  endtask

  task automatic wait_irq(input logic [NUM_BANKS-1:0] expected);
    int n;
    n = 0;
    while ((o_irq !== expected) && (n < IRQ_TIMEOUT)) begin
      @(posedge tb_hclk19);
      #1;
      n++;
    end
    compare_value("o_irq", expected, o_irq);
  endtask

  task automatic run_command(input logic [7:0] c, input logic [31:0] a,
                             input logic [31:0] data, input logic [31:0] expected);
    case (c)
      "W": ahb_write(a, data);
      "R": ahb_read(a, expected);
      "E": ahb_error(a, data);
      "Q": wait_irq(expected[NUM_BANKS-1:0]);
      "P": begin
        i_gpio_in = data;                // All banks' pins at once
        repeat (PIN_SETTLE) @(posedge tb_hclk19);
        #1;
      end
      default: begin
        $display("unknown operation in input file line %0d", lineno);
        errors++;
      end
    endcase
  endtask

  task automatic finish_test(input string name);
    tests++;
    if (errors == err_mark) begin
      passed++;
      $display("test %s: pass", name);
    end else begin
      $display("test %s: FAIL, %0d errors", name, errors - err_mark);
    end
    err_mark = errors;
  endtask

  // ==========================================================================
  // Sequence
  // ==========================================================================
  initial begin
    tb_hclk19   = 1'b0;
    hresetn19   = 1'b0;
    i_hsel      = 1'b0;
    i_haddr     = '0;
    i_htrans    = 2'b00;                 // IDLE
    i_hwrite    = 1'b0;
    i_hwdata    = '0;
    i_hready_in = 1'b1;
    i_gpio_in   = '0;
    exp_out     = '0;
    exp_dir     = '0;
    seed        = 32'd86477;
    errors      = 0;
    err_mark    = 0;
    tests       = 0;
    passed      = 0;
    lineno      = 0;
    repeat (10) @(posedge tb_hclk19);
    #1;
    hresetn19 = 1'b1;

    compare_value("o_hready", 1, o_hready);
    compare_value("o_hresp", HRESP_OKAY, o_hresp);
    compare_value("o_gpio_n_oe", '1, o_gpio_n_oe);  // All pins inputs
    compare_value("o_irq", 0, o_irq);
    finish_test("reset_outputs");

    for (int b = 0; b < NUM_BANKS; b++) begin
      for (int r = 0; r <= REG_IRQ_MASK; r++) begin
        addr = (b << BANK_LSB) | (r << REG_LSB);
        if ((r != REG_DIN) && (r != REG_IRQ_STAT)) ahb_read(addr, 32'h0);
      end
    end
    finish_test("reset_readback");

    // Write then read back at once, so each read starts in the DONE cycle
    for (int b = 0; b < NUM_BANKS; b++) begin
      for (int r = 0; r <= REG_IRQ_MASK; r++) begin
        addr = (b << BANK_LSB) | (r << REG_LSB);
        if ((r != REG_DIN) && (r != REG_IRQ_STAT)) begin
          seed = lcg_next(seed);
          ahb_write(addr, {24'h0, seed[23:16]});
          ahb_read(addr, {24'h0, seed[23:16]});
        end
      end
    end
    finish_test("random_rw");

    fd = $fopen("verif/apb_ss_input.txt", "r");
    if (fd == 0) begin
      $display("could not open verif/apb_ss_input.txt");
      errors++;
      finish_test("input_file");
    end else begin
      while ($fgets(line, fd) != 0) begin
        lineno++;
        if ((line.len() > 1) && (line.getc(0) != "#")) begin
          if ($sscanf(line, "%c %h %h %h", op, f_addr, f_data, f_exp) != 4) begin
            $display("input file line %0d could not be parsed", lineno);
            errors++;
          end else begin
            run_command(op, f_addr, f_data, f_exp);
          end
          finish_test($sformatf("line %0d %c %h", lineno, op, f_addr));
        end
      end
      $fclose(fd);
    end

    $display("tests %0d, passed %0d, errors %0d", tests, passed, errors);
    if (errors == 0) begin
      $display("Done: no errors");
    end else begin
      $display("Done: errors found");
    end
    $finish;
  end

endmodule

//--- verif/apb_ss_input.txt
# op addr data expect, hex after the op letter
# W write, R read, P set pins, E expect error, Q expect irq vector
W 00000000 000000a5 00000000
R 00000000 00000000 000000a5
W 00000204 00000011 00000000
R 00000204 00000000 00000011
W 00000110 0000000f 00000000
W 00000210 00000000 00000000
P 00000000 00000300 00000000
R 00000108 00000000 00000003
R 0000010c 00000000 00000003
Q 00000000 00000000 00000002
P 00000000 00000200 00000000
R 0000010c 00000000 00000003
W 0000010c 00000001 00000000
R 0000010c 00000000 00000002
Q 00000000 00000000 00000002
W 0000010c 00000002 00000000
Q 00000000 00000000 00000000
P 00000000 00f00200 00000000
R 0000020c 00000000 000000f0
R 00000208 00000000 000000f0
Q 00000000 00000000 00000000
E 00000400 000000ff 00000000
E 00000014 000000ff 00000000
E 0000021c 000000ff 00000000
E 00000f04 000000ff 00000000
R 00000000 00000000 000000a5
R 00000204 00000000 00000011

//--- apb_ss_top.f
logic/apb_ss_pkg.sv
logic/ahb_apb_bridge.sv
logic/gpio_bank.sv
logic/apb_read_return.sv
logic/apb_ss_top.sv
verif/apb_ss_tb.sv

//--- Makefile
SIM     = verilator
FLAGS   = --binary --timing --assert -Wno-fatal
TOP     = apb_ss_tb
FLIST   = apb_ss_top.f
OBJ_DIR = obj_dir
LOG     = sim.log
FAIL    = Done: errors found
PASS    = Done: no errors

.PHONY: all compile run clean

all: run

compile:
	$(SIM) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FLIST)

run: compile
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@if grep -q "$(FAIL)" $(LOG); then echo "SIMULATION FAILED"; exit 1; fi
	@if ! grep -q "$(PASS)" $(LOG); then echo "SIMULATION INCOMPLETE"; exit 1; fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
